/* hdl/rvDecodeCfg.svh */
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// ==================================================
// datapath sizing for the decode stage
// ==================================================

// instruction and data words share one width
`define XLEN 32

// architectural register file depth and index width
`define REG_COUNT 32
`define REG_IDX_W 5

`endif

/* hdl/rvIsaPkg.sv */
package rvIsaPkg;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeS;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeS;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeS;

    // branch offsets are scattered so that the sign bit stays at bit 31
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeS;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeS;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeS;

    typedef union packed {
        rTypeS r;
        iTypeS i;
        sTypeS s;
        bTypeS b;
        uTypeS u;
        jTypeS j;
    } rvInstrU;

endpackage

/* hdl/rvCtrlPkg.sv */
package rvCtrlPkg;

    // what the writeback mux selects
    typedef enum logic [1:0] {
        aluResult = 2'b00,
        memData   = 2'b01,
        pcPlus4   = 2'b10
    } resultSrcE;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immU = 3'b001,
        immS = 3'b010,
        immB = 3'b011,
        immJ = 3'b100
    } immSrcE;

    // coarse class handed from the main decoder to the ALU decoder
    typedef enum logic [1:0] {
        aluMemAdd    = 2'b00,
        aluBranchSub = 2'b01,
        aluFunct     = 2'b10,
        aluPassImm   = 2'b11
    } aluOpE;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10
    } aluCtrlE;

endpackage

/* hdl/ctrlBus.sv */
`timescale 1ns/1ps

interface ctrlBus
    import rvCtrlPkg::*;
();

    logic      regWrite;
    resultSrcE resultSrc;
    logic      memWrite;
    logic      aluSrc;
    aluCtrlE   aluControl;
    logic      branch;
    logic [2:0] branchCond;
    logic      jump;
    logic      illegal;

    // the decoders fill the word, the pipeline register samples it
    modport src (
        output regWrite, resultSrc, memWrite, aluSrc, aluControl,
        output branch, branchCond, jump, illegal
    );

    modport dst (
        input regWrite, resultSrc, memWrite, aluSrc, aluControl,
        input branch, branchCond, jump, illegal
    );

endinterface

/* hdl/mainDecoder.sv */
`timescale 1ns/1ps

module mainDecoder
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  rvInstrU instr,
    ctrlBus.src     ctrl,
    output immSrcE  immSrc,
    output aluOpE   aluOp
);

    typedef enum logic [3:0] {
        undefKind,
        rKind,
        addiKind,
        slliKind,
        lwKind,
        luiKind,
        storeKind,
        branchKind,
        jalKind,
        jalrKind
    } kindE;

    kindE kind;

    // ==================================================
    // instruction classification
    // ==================================================

    always_comb begin
        unique case (instr.r.opcode)
            OP_R:      kind = rKind;
            OP_IMM:    kind = (instr.r.funct3 == 3'b000) ? addiKind :
                              (instr.r.funct3 == 3'b001) ? slliKind : undefKind;
            OP_LOAD:   kind = (instr.r.funct3 == 3'b010) ? lwKind : undefKind;
            OP_LUI:    kind = luiKind;
            OP_STORE:  kind = storeKind;
            OP_BRANCH: kind = branchKind;
            OP_JAL:    kind = jalKind;
            OP_JALR:   kind = jalrKind;
            default:   kind = undefKind;
        endcase
    end

    // ==================================================
    // control word
    // ==================================================

    always_comb begin
        ctrl.regWrite = kind inside {rKind, addiKind, slliKind, lwKind, luiKind,
                                     jalKind, jalrKind};
        ctrl.memWrite = (kind == storeKind);
        ctrl.aluSrc   = kind inside {addiKind, slliKind, lwKind, luiKind, storeKind};
        ctrl.branch   = (kind == branchKind);
        ctrl.jump     = kind inside {jalKind, jalrKind};
        ctrl.illegal  = (kind == undefKind);

        // execute resolves the branch from funct3 directly
        ctrl.branchCond = instr.r.funct3;

        if (kind == lwKind)
            ctrl.resultSrc = memData;
        else if (kind inside {jalKind, jalrKind})
            ctrl.resultSrc = pcPlus4;
        else
            ctrl.resultSrc = aluResult;

        case (kind)
            luiKind:    immSrc = immU;
            storeKind:  immSrc = immS;
            branchKind: immSrc = immB;
            jalKind:    immSrc = immJ;
            default:    immSrc = immI;
        endcase

        case (kind)
            lwKind, storeKind: aluOp = aluMemAdd;
            branchKind:        aluOp = aluBranchSub;
            luiKind:           aluOp = aluPassImm;
            default:           aluOp = aluFunct;
        endcase
    end

endmodule

/* hdl/aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  aluOpE   aluOp,
    input  rvInstrU instr,
    ctrlBus.src     ctrl
);

    logic subSel;
    logic shiftArith;

    // register sub needs both bits so that addi with a high imm bit 10 stays an add
    assign subSel     = instr.r.funct7[5] & instr.r.opcode[5];
    assign shiftArith = instr.r.funct7[5];

    always_comb begin
        case (aluOp)
            aluMemAdd:    ctrl.aluControl = aluAdd;
            aluBranchSub: ctrl.aluControl = aluSub;
            aluPassImm:   ctrl.aluControl = aluPassB;
            default: begin
                case (instr.r.funct3)
                    3'b000:  ctrl.aluControl = subSel ? aluSub : aluAdd;
                    3'b001:  ctrl.aluControl = aluSll;
                    3'b010:  ctrl.aluControl = aluSlt;
                    3'b011:  ctrl.aluControl = aluSltu;
                    3'b100:  ctrl.aluControl = aluXor;
                    3'b101:  ctrl.aluControl = shiftArith ? aluSra : aluSrl;
                    3'b110:  ctrl.aluControl = aluOr;
                    default: ctrl.aluControl = aluAnd;
                endcase
            end
        endcase
    end

endmodule

/* hdl/immExtend.sv */
`timescale 1ns/1ps
`include "rvDecodeCfg.svh"

module immExtend
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  rvInstrU          instr,
    input  immSrcE           immSrc,
    output logic [`XLEN-1:0] immExt
);

    // every format keeps its sign in bit 31 of the word
    always_comb begin
        case (immSrc)
            immI: begin
                immExt = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            end
            immS: begin
                immExt = {{(`XLEN-12){instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            end
            immB: begin
                immExt = {{(`XLEN-13){instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                          instr.b.imm10to5, instr.b.imm4to1, 1'b0};
            end
            immU: begin
                immExt = `XLEN'($signed({instr.u.imm, 12'h000}));
            end
            immJ: begin
                immExt = {{(`XLEN-21){instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                          instr.j.imm11, instr.j.imm10to1, 1'b0};
            end
            default: begin
                immExt = '0;
            end
        endcase
    end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps
`include "rvDecodeCfg.svh"

module regFile (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [`REG_IDX_W-1:0] rs1,
    input  logic [`REG_IDX_W-1:0] rs2,
    input  logic                  we,
    input  logic [`REG_IDX_W-1:0] rd,
    input  logic [`XLEN-1:0]      wd,
    output logic [`XLEN-1:0]      rd1,
    output logic [`XLEN-1:0]      rd2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // writeback in the same cycle is forwarded so decode never sees a stale value
    always_comb begin
        if (rs1 == '0)
            rd1 = '0;
        else if (we && rd == rs1)
            rd1 = wd;
        else
            rd1 = regs[rs1];

        if (rs2 == '0)
            rd2 = '0;
        else if (we && rd == rs2)
            rd2 = wd;
        else
            rd2 = regs[rs2];
    end

endmodule

/* hdl/decodeExecuteReg.sv */
`timescale 1ns/1ps
`include "rvDecodeCfg.svh"

module decodeExecuteReg (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  stall,
    input  logic                  flush,
    ctrlBus.dst                   ctrl,
    input  logic [`XLEN-1:0]      rs1Data,
    input  logic [`XLEN-1:0]      rs2Data,
    input  logic [`XLEN-1:0]      immExt,
    input  logic [`REG_IDX_W-1:0] rd,
    input  logic [`XLEN-1:0]      pc,
    output logic                  regWriteE,
    output logic [1:0]            resultSrcE,
    output logic                  memWriteE,
    output logic                  aluSrcE,
    output logic [3:0]            aluControlE,
    output logic                  branchE,
    output logic [2:0]            branchCondE,
    output logic                  jumpE,
    output logic                  illegalE,
    output logic [`XLEN-1:0]      rs1DataE,
    output logic [`XLEN-1:0]      rs2DataE,
    output logic [`XLEN-1:0]      immExtE,
    output logic [`REG_IDX_W-1:0] rdE,
    output logic [`XLEN-1:0]      pcE
);

    // ==================================================
    // a flush turns the control half into a bubble
    // ==================================================

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            regWriteE   <= 1'b0;
            resultSrcE  <= '0;
            memWriteE   <= 1'b0;
            aluSrcE     <= 1'b0;
            aluControlE <= '0;
            branchE     <= 1'b0;
            branchCondE <= '0;
            jumpE       <= 1'b0;
            illegalE    <= 1'b0;
        end else if (!stall) begin
            regWriteE   <= ctrl.regWrite;
            resultSrcE  <= ctrl.resultSrc;
            memWriteE   <= ctrl.memWrite;
            aluSrcE     <= ctrl.aluSrc;
            aluControlE <= ctrl.aluControl;
            branchE     <= ctrl.branch;
            branchCondE <= ctrl.branchCond;
            jumpE       <= ctrl.jump;
            illegalE    <= ctrl.illegal;
        end
    end

    // the data half holds during a stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            rs1DataE <= rs1Data;
            rs2DataE <= rs2Data;
            immExtE  <= immExt;
            rdE      <= rd;
            pcE      <= pc;
        end
    end

endmodule

/* hdl/decodeStage.sv */
`timescale 1ns/1ps
`include "rvDecodeCfg.svh"

module decodeStage
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [`XLEN-1:0]      instrD,
    input  logic [`XLEN-1:0]      pcD,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  wbWe,
    input  logic [`REG_IDX_W-1:0] wbRd,
    input  logic [`XLEN-1:0]      wbData,
    output logic                  regWriteE,
    output logic [1:0]            resultSrcE,
    output logic                  memWriteE,
    output logic                  aluSrcE,
    output logic [3:0]            aluControlE,
    output logic                  branchE,
    output logic [2:0]            branchCondE,
    output logic                  jumpE,
    output logic                  illegalE,
    output logic [`XLEN-1:0]      rs1DataE,
    output logic [`XLEN-1:0]      rs2DataE,
    output logic [`XLEN-1:0]      immExtE,
    output logic [`REG_IDX_W-1:0] rdE,
    output logic [`XLEN-1:0]      pcE
);

    rvInstrU          instr;
    immSrcE           immSrc;
    aluOpE            aluOp;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] immExt;

    assign instr = instrD;

    ctrlBus ctrl ();

    mainDecoder mainDecoder_i (
        .instr  (instr),
        .ctrl   (ctrl.src),
        .immSrc (immSrc),
        .aluOp  (aluOp)
    );

    aluDecoder aluDecoder_i (
        .aluOp (aluOp),
        .instr (instr),
        .ctrl  (ctrl.src)
    );

    immExtend immExtend_i (
        .instr  (instr),
        .immSrc (immSrc),
        .immExt (immExt)
    );

    // register reads use the R view since rs1 and rs2 sit at fixed bits
    regFile regFile_i (
        .clk  (clk),
        .rstN (rstN),
        .rs1  (instr.r.rs1),
        .rs2  (instr.r.rs2),
        .we   (wbWe),
        .rd   (wbRd),
        .wd   (wbData),
        .rd1  (rs1Data),
        .rd2  (rs2Data)
    );

    decodeExecuteReg decodeExecuteReg_i (
        .clk         (clk),
        .rstN        (rstN),
        .stall       (stall),
        .flush       (flush),
        .ctrl        (ctrl.dst),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .immExt      (immExt),
        .rd          (instr.r.rd),
        .pc          (pcD),
        .regWriteE   (regWriteE),
        .resultSrcE  (resultSrcE),
        .memWriteE   (memWriteE),
        .aluSrcE     (aluSrcE),
        .aluControlE (aluControlE),
        .branchE     (branchE),
        .branchCondE (branchCondE),
        .jumpE       (jumpE),
        .illegalE    (illegalE),
        .rs1DataE    (rs1DataE),
        .rs2DataE    (rs2DataE),
        .immExtE     (immExtE),
        .rdE         (rdE),
        .pcE         (pcE)
    );

endmodule

/* verif/decodeStageTb.sv */
`timescale 1ns/1ps
`include "rvDecodeCfg.svh"

module decodeStageTb
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
();

    localparam int clkPeriod   = 20;
    localparam int resetCycles = 2;
    localparam int numCycles   = 3000;

    localparam int kindUndef  = 0;
    localparam int kindR      = 1;
    localparam int kindAddi   = 2;
    localparam int kindSlli   = 3;
    localparam int kindLw     = 4;
    localparam int kindLui    = 5;
    localparam int kindSw     = 6;
    localparam int kindBranch = 7;
    localparam int kindJal    = 8;
    localparam int kindJalr   = 9;

    logic                  clk;
    logic                  rstN;
    logic [`XLEN-1:0]      instrD;
    logic [`XLEN-1:0]      pcD;
    logic                  stall;
    logic                  flush;
    logic                  wbWe;
    logic [`REG_IDX_W-1:0] wbRd;
    logic [`XLEN-1:0]      wbData;
    logic                  regWriteE;
    logic [1:0]            resultSrcE;
    logic                  memWriteE;
    logic                  aluSrcE;
    logic [3:0]            aluControlE;
    logic                  branchE;
    logic [2:0]            branchCondE;
    logic                  jumpE;
    logic                  illegalE;
    logic [`XLEN-1:0]      rs1DataE;
    logic [`XLEN-1:0]      rs2DataE;
    logic [`XLEN-1:0]      immExtE;
    logic [`REG_IDX_W-1:0] rdE;
    logic [`XLEN-1:0]      pcE;

    // ==================================================
    // reference model state
    // ==================================================

    logic [`XLEN-1:0] shadowRegs [`REG_COUNT];

    logic             eRegWrite, eMemWrite, eBranch, eJump, eIllegal, eAluSrc;
    logic [1:0]       eResult;
    logic [3:0]       eAluCtrl;
    logic [2:0]       eBranchCond;
    logic [`XLEN-1:0] eImm, eRs1, eRs2, ePc;
    logic [4:0]       eRd;

    // fields that a kind leaves open, or that follow a bubble, are not compared
    logic cResult, cAluSrc, cAluCtrl, cBranchCond, cImm, cData;

    decodeStage decodeStage_i (
        .clk(clk), .rstN(rstN), .instrD(instrD), .pcD(pcD),
        .stall(stall), .flush(flush), .wbWe(wbWe), .wbRd(wbRd), .wbData(wbData),
        .regWriteE(regWriteE), .resultSrcE(resultSrcE), .memWriteE(memWriteE),
        .aluSrcE(aluSrcE), .aluControlE(aluControlE), .branchE(branchE),
        .branchCondE(branchCondE), .jumpE(jumpE), .illegalE(illegalE),
        .rs1DataE(rs1DataE), .rs2DataE(rs2DataE), .immExtE(immExtE),
        .rdE(rdE), .pcE(pcE)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #((numCycles + resetCycles + 50) * clkPeriod);
        $display("timeout: the run did not finish within the expected number of cycles");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic int kindOf(logic [31:0] w);
        case (w[6:0])
            OP_R:      return kindR;
            OP_IMM:    return (w[14:12] == 3'd0) ? kindAddi :
                              (w[14:12] == 3'd1) ? kindSlli : kindUndef;
            OP_LOAD:   return (w[14:12] == 3'd2) ? kindLw : kindUndef;
            OP_LUI:    return kindLui;
            OP_STORE:  return kindSw;
            OP_BRANCH: return kindBranch;
            OP_JAL:    return kindJal;
            OP_JALR:   return kindJalr;
            default:   return kindUndef;
        endcase
    endfunction

    function automatic logic [31:0] immOf(int kind, logic [31:0] w);
        case (kind)
            kindSw:     return {{20{w[31]}}, w[31:25], w[11:7]};
            kindBranch: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            kindLui:    return {w[31:12], 12'h000};
            kindJal:    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:    return {{20{w[31]}}, w[31:20]};
        endcase
    endfunction

    function automatic logic [3:0] aluCtrlOf(int kind, logic [31:0] w);
        if (kind == kindLw || kind == kindSw)
            return aluAdd;
        if (kind == kindBranch)
            return aluSub;
        if (kind == kindLui)
            return aluPassB;
        case (w[14:12])
            3'd0:    return (w[30] && w[5]) ? aluSub : aluAdd;
            3'd1:    return aluSll;
            3'd2:    return aluSlt;
            3'd3:    return aluSltu;
            3'd4:    return aluXor;
            3'd5:    return w[30] ? aluSra : aluSrl;
            3'd6:    return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    // a register being written back in the same cycle is read as the new value
    function automatic logic [31:0] readReg(logic [4:0] idx);
        if (idx == 5'd0)
            return '0;
        if (wbWe && wbRd == idx)
            return wbData;
        return shadowRegs[idx];
    endfunction

    function automatic logic [31:0] randomInstr();
        logic [31:0] w;
        int          f3;
        w = $urandom;
        if ($urandom_range(0, 99) < 10)
            return w;
        case ($urandom_range(0, 10))
            0: w = {1'b0, w[30], 5'b0, w[24:0]} & 32'hffff_ff80 | OP_R;
            1: w = {w[31:15], 3'd0, w[11:7], OP_IMM};
            2: w = {7'd0, w[24:15], 3'd1, w[11:7], OP_IMM};
            3: w = {w[31:15], 3'd2, w[11:7], OP_LOAD};
            4: w = {w[31:7], OP_LUI};
            5: w = {w[31:15], 3'd2, w[11:7], OP_STORE};
            6: w = {w[31:7], OP_BRANCH};
            7: w = {w[31:7], OP_JAL};
            8: w = {w[31:15], 3'd0, w[11:7], OP_JALR};
            // unsupported funct3 values on opcodes that are otherwise known
            9: w = {w[31:15], 3'($urandom_range(2, 7)), w[11:7], OP_IMM};
            default: begin
                f3 = $urandom_range(0, 6);
                if (f3 >= 2)
                    f3++;
                w = {w[31:15], 3'(f3), w[11:7], OP_LOAD};
            end
        endcase
        return w;
    endfunction

    task automatic clearControl();
        eRegWrite   = 1'b0;
        eMemWrite   = 1'b0;
        eBranch     = 1'b0;
        eJump       = 1'b0;
        eIllegal    = 1'b0;
        cResult     = 1'b0;
        cAluSrc     = 1'b0;
        cAluCtrl    = 1'b0;
        cBranchCond = 1'b0;
        cImm        = 1'b0;
        cData       = 1'b0;
    endtask

    task automatic driveCycle();
        logic [31:0] w;
        w = randomInstr();
        instrD <= w;
        pcD    <= $urandom & 32'hffff_fffc;
        rstN   <= ($urandom_range(0, 199) != 0);
        stall  <= ($urandom_range(0, 99) < 15);
        flush  <= ($urandom_range(0, 99) < 8);
        wbWe   <= ($urandom_range(0, 99) < 60);
        wbData <= $urandom;
        case ($urandom_range(0, 3))
            0:       wbRd <= w[19:15];
            1:       wbRd <= w[24:20];
            default: wbRd <= 5'($urandom_range(0, 31));
        endcase
    endtask

    // ==================================================
    // model step for the coming clock edge
    // ==================================================

    task automatic advanceModel();
        int          kind;
        logic [31:0] w;
        w    = instrD;
        kind = kindOf(w);
        if (!rstN) begin
            clearControl();
            foreach (shadowRegs[i])
                shadowRegs[i] = '0;
        end else if (flush) begin
            clearControl();
        end else if (!stall) begin
            eRegWrite   = kind inside {kindR, kindAddi, kindSlli, kindLw, kindLui,
                                       kindJal, kindJalr};
            eMemWrite   = (kind == kindSw);
            eBranch     = (kind == kindBranch);
            eJump       = kind inside {kindJal, kindJalr};
            eIllegal    = (kind == kindUndef);
            cResult     = eRegWrite;
            eResult     = (kind == kindLw) ? memData : eJump ? pcPlus4 : aluResult;
            cAluSrc     = kind inside {kindR, kindAddi, kindSlli, kindLw, kindLui,
                                       kindSw, kindBranch};
            eAluSrc     = kind inside {kindAddi, kindSlli, kindLw, kindLui, kindSw};
            cAluCtrl    = cAluSrc;
            eAluCtrl    = aluCtrlOf(kind, w);
            cBranchCond = eBranch;
            eBranchCond = w[14:12];
            cImm        = !(kind inside {kindR, kindUndef});
            eImm        = immOf(kind, w);
            cData       = 1'b1;
            eRs1        = readReg(w[19:15]);
            eRs2        = readReg(w[24:20]);
            eRd         = w[11:7];
            ePc         = pcD;
        end
        if (rstN && wbWe && wbRd != 5'd0)
            shadowRegs[wbRd] = wbData;
    endtask

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic checkOutputs();
        checkField("regWriteE", regWriteE, eRegWrite);
        checkField("memWriteE", memWriteE, eMemWrite);
        checkField("branchE", branchE, eBranch);
        checkField("jumpE", jumpE, eJump);
        checkField("illegalE", illegalE, eIllegal);
        if (cResult)
            checkField("resultSrcE", resultSrcE, eResult);
        if (cAluSrc)
            checkField("aluSrcE", aluSrcE, eAluSrc);
        if (cAluCtrl)
            checkField("aluControlE", aluControlE, eAluCtrl);
        if (cBranchCond)
            checkField("branchCondE", branchCondE, eBranchCond);
        if (cImm)
            checkField("immExtE", immExtE, eImm);
        if (cData) begin
            checkField("rs1DataE", rs1DataE, eRs1);
            checkField("rs2DataE", rs2DataE, eRs2);
            checkField("rdE", rdE, eRd);
            checkField("pcE", pcE, ePc);
        end
    endtask

    initial begin
        void'($urandom(32'h327ef5b1));
        rstN   = 1'b0;
        instrD = '0;
        pcD    = '0;
        stall  = 1'b0;
        flush  = 1'b0;
        wbWe   = 1'b0;
        wbRd   = '0;
        wbData = '0;
        foreach (shadowRegs[i])
            shadowRegs[i] = '0;
        clearControl();
        repeat (resetCycles) @(posedge clk);

        // outputs are compared at the falling edge half a period after capture
        for (int n = 0; n < numCycles; n++) begin
            driveCycle();
            @(negedge clk);
            checkOutputs();
            advanceModel();
            @(posedge clk);
        end
        @(negedge clk);
        checkOutputs();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* project.f */
+incdir+hdl
hdl/rvIsaPkg.sv
hdl/rvCtrlPkg.sv
hdl/ctrlBus.sv
hdl/mainDecoder.sv
hdl/aluDecoder.sv
hdl/immExtend.sv
hdl/regFile.sv
hdl/decodeExecuteReg.sv
hdl/decodeStage.sv
verif/decodeStageTb.sv

/* Bender.yml */
package:
  name: rv_decode_stage

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rvIsaPkg.sv
      - hdl/rvCtrlPkg.sv
      - hdl/ctrlBus.sv
      - hdl/mainDecoder.sv
      - hdl/aluDecoder.sv
      - hdl/immExtend.sv
      - hdl/regFile.sv
      - hdl/decodeExecuteReg.sv
      - hdl/decodeStage.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/decodeStageTb.sv
